//--- design/cdp_bufin_pkg.sv
// cdp buffer-in shared definitions
// window geometry, field widths and state encoding
`default_nettype none

package cdp_bufin_pkg;

  // channels in one window, centre plus four on each side
  localparam int win_taps = 9;
  // fill depth and number of flush rounds
  localparam int half_win = 4;

  // width position or width value
  typedef logic [3:0] pos_w_t;
  // output channel index within a cube
  typedef logic [7:0] chan_t;
  // flush round index
  typedef logic [2:0] round_t;

  typedef enum logic [1:0] {
    st_fill   = 2'd0,
    st_normal = 2'd1,
    st_flush  = 2'd2
  } bufin_state_e;

endpackage

`default_nettype wire

//--- design/cdp_bufin_pipe.sv
// cdp buffer-in register stage
// one valid/ready slot, refills in the cycle the held beat leaves
`default_nettype none

module cdp_bufin_pipe #(
  parameter int dw = 8
) (
  input  logic          nvdla_core_clk,
  input  logic          nvdla_core_rstn,
  input  logic          in_valid,
  output logic          in_ready,
  input  logic [dw-1:0] in_pd,
  output logic          out_valid,
  input  logic          out_ready,
  output logic [dw-1:0] out_pd
);

  // open when empty or when the held beat is taken now
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // data slot
  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      out_pd <= in_pd;
    end
  end

  // sender keeps a waiting beat and its payload
  a_pipe_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    in_valid && !in_ready |=> in_valid && $stable(in_pd));

endmodule

`default_nettype wire

//--- design/cdp_bufin_fsm.sv
// cdp buffer-in control FSM
// fill / normal / flush sequencing of push, emit and clear
`default_nettype none

module cdp_bufin_fsm (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        beat_valid,
  input  logic                        b_sync,
  input  logic                        last_c,
  input  logic                        stage_en,
  input  logic                        flush_done,
  output logic                        beat_ready,
  output logic                        advance,
  output logic                        push_zero,
  output logic                        emit,
  output logic                        clear,
  output cdp_bufin_pkg::bufin_state_e state
);

  localparam int fill_w = $clog2(cdp_bufin_pkg::half_win);

  cdp_bufin_pkg::bufin_state_e state_nxt;
  logic [fill_w-1:0]           fill_cnt;
  logic                        row_done;
  logic                        fill_last;

  //////////////////////////////
  // step controls
  //////////////////////////////
  // flush pushes zeros and keeps the input parked
  assign push_zero  = (state == cdp_bufin_pkg::st_flush);
  assign beat_ready = stage_en & ~push_zero;
  assign advance    = push_zero ? stage_en : (beat_valid & stage_en);
  // nothing leaves while the first channels fill
  assign emit       = (state != cdp_bufin_pkg::st_fill);
  assign clear      = push_zero & flush_done;

  // end of one input channel row
  assign row_done  = advance & ~push_zero & b_sync;
  assign fill_last = (fill_cnt == fill_w'(cdp_bufin_pkg::half_win - 1));

  //////////////////////////////
  // state transitions
  //////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      cdp_bufin_pkg::st_fill: begin
        // a four channel cube goes straight to flush
        if (row_done && last_c) begin
          state_nxt = cdp_bufin_pkg::st_flush;
        end else if (row_done && fill_last) begin
          state_nxt = cdp_bufin_pkg::st_normal;
        end
      end
      cdp_bufin_pkg::st_normal: begin
        if (row_done && last_c) begin
          state_nxt = cdp_bufin_pkg::st_flush;
        end
      end
      cdp_bufin_pkg::st_flush: begin
        if (flush_done) begin
          state_nxt = cdp_bufin_pkg::st_fill;
        end
      end
      default: begin
        state_nxt = cdp_bufin_pkg::st_fill;
      end
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= cdp_bufin_pkg::st_fill;
    end else begin
      state <= state_nxt;
    end
  end

  // rows seen so far in fill
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      fill_cnt <= '0;
    end else if (state != cdp_bufin_pkg::st_fill) begin
      fill_cnt <= '0;
    end else if (row_done) begin
      fill_cnt <= fill_cnt + fill_w'(1);
    end
  end

  // cube end never arrives before the fourth channel row
  a_min_chan: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    state == cdp_bufin_pkg::st_fill && row_done && last_c |-> fill_last);

endmodule

`default_nettype wire

//--- design/cdp_bufin_flush_cnt.sv
// cdp buffer-in flush counter
// walks width positions and zero rounds after the cube end
`default_nettype none

module cdp_bufin_flush_cnt #(
  parameter int max_width = 8
) (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  cdp_bufin_pkg::bufin_state_e state,
  input  logic                        advance,
  input  cdp_bufin_pkg::pos_w_t       in_width,
  output cdp_bufin_pkg::pos_w_t       flush_pos_w,
  output logic                        flush_done
);

  cdp_bufin_pkg::pos_w_t cube_width;
  cdp_bufin_pkg::pos_w_t pos_cnt;
  cdp_bufin_pkg::round_t round_cnt;
  logic                  in_flush;
  logic                  pos_last;
  logic                  round_last;

  assign in_flush   = (state == cdp_bufin_pkg::st_flush);
  assign pos_last   = (pos_cnt == cube_width - cdp_bufin_pkg::pos_w_t'(1));
  assign round_last = (round_cnt == cdp_bufin_pkg::round_t'(cdp_bufin_pkg::half_win - 1));
  // last zero of the last round
  assign flush_done  = in_flush & advance & pos_last & round_last;
  assign flush_pos_w = pos_cnt;

  // width of the cube in flight
  // the parked beat in flush may already be the next cube
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cube_width <= '0;
    end else if (!in_flush && advance) begin
      cube_width <= in_width;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pos_cnt   <= '0;
      round_cnt <= '0;
    end else if (!in_flush) begin
      pos_cnt   <= '0;
      round_cnt <= '0;
    end else if (advance) begin
      if (pos_last) begin
        // row wrap, next round
        pos_cnt   <= '0;
        round_cnt <= round_cnt + cdp_bufin_pkg::round_t'(1);
      end else begin
        pos_cnt <= pos_cnt + cdp_bufin_pkg::pos_w_t'(1);
      end
    end
  end

  // flush never addresses a row the window store lacks
  a_pos_range: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    in_flush |-> int'(pos_cnt) < max_width);

endmodule

`default_nettype wire

//--- design/cdp_bufin_window.sv
// cdp buffer-in window store
// nine channel taps per width position, shifted on push
// the shifted row leaves as one nine-lane window
`default_nettype none

module cdp_bufin_window #(
  parameter int elem_w    = 8,
  parameter int max_width = 8
) (
  input  logic                                    nvdla_core_clk,
  input  logic                                    nvdla_core_rstn,
  input  logic                                    advance,
  input  logic                                    push_zero,
  input  logic                                    clear,
  input  cdp_bufin_pkg::pos_w_t                   sel_pos_w,
  input  logic [elem_w-1:0]                       din,
  input  logic                                    emit,
  output logic                                    win_valid,
  input  logic                                    win_ready,
  output logic [cdp_bufin_pkg::win_taps*elem_w-1:0] win_data
);

  localparam int data_w = cdp_bufin_pkg::win_taps * elem_w;
  localparam int row_w  = (max_width > 1) ? $clog2(max_width) : 1;

  // tap 0 holds the newest channel
  typedef logic [cdp_bufin_pkg::win_taps-1:0][elem_w-1:0] row_t;

  row_t              store [max_width];
  row_t              row_nxt;
  logic [row_w-1:0]  row_sel;
  logic [elem_w-1:0] push_val;
  logic [data_w-1:0] win_nxt;

  assign row_sel  = row_w'(sel_pos_w);
  // zeros during flush
  assign push_val = push_zero ? '0 : din;
  assign row_nxt  = {store[row_sel][cdp_bufin_pkg::win_taps-2:0], push_val};

  // lane k is channel c-4+k, so the oldest tap lands in lane 0
  always_comb begin
    for (int k = 0; k < cdp_bufin_pkg::win_taps; k++) begin
      win_nxt[k*elem_w +: elem_w] = row_nxt[cdp_bufin_pkg::win_taps-1-k];
    end
  end

  //////////////////////////////
  // tap store
  //////////////////////////////
  // zero start so lanes before channel 0 read as zero
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int r = 0; r < max_width; r++) begin
        store[r] <= '0;
      end
    end else if (clear) begin
      // cube done, drop leftovers before the next one
      for (int r = 0; r < max_width; r++) begin
        store[r] <= '0;
      end
    end else if (advance) begin
      store[row_sel] <= row_nxt;
    end
  end

  //////////////////////////////
  // window out
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      win_valid <= 1'b0;
    end else if (advance) begin
      win_valid <= emit;
    end else if (win_ready) begin
      win_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (advance) begin
      win_data <= win_nxt;
    end
  end

endmodule

`default_nettype wire

//--- design/cdp_bufin_info.sv
// cdp buffer-in sideband alignment
// pos_w, width, channel index and sync flags for each window
`default_nettype none

module cdp_bufin_info (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        advance,
  input  logic                        emit,
  input  logic                        clear,
  input  cdp_bufin_pkg::bufin_state_e state,
  input  cdp_bufin_pkg::pos_w_t       sel_pos_w,
  input  cdp_bufin_pkg::pos_w_t       in_width,
  input  logic                        flush_done,
  output cdp_bufin_pkg::pos_w_t       info_pos_w,
  output cdp_bufin_pkg::pos_w_t       info_width,
  output cdp_bufin_pkg::chan_t        info_pos_c,
  output logic                        info_b_sync,
  output logic                        info_last_c
);

  cdp_bufin_pkg::pos_w_t cube_width;
  cdp_bufin_pkg::pos_w_t cur_width;
  cdp_bufin_pkg::chan_t  chan_cnt;
  logic                  in_flush;
  logic                  row_end;
  logic                  emit_now;

  assign in_flush  = (state == cdp_bufin_pkg::st_flush);
  // held width during flush, live width otherwise
  assign cur_width = in_flush ? cube_width : in_width;
  assign row_end   = (sel_pos_w == cur_width - cdp_bufin_pkg::pos_w_t'(1));
  assign emit_now  = advance & emit;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cube_width <= '0;
    end else if (!in_flush && advance) begin
      cube_width <= in_width;
    end
  end

  // output channel, steps at each emitted row end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      chan_cnt <= '0;
    end else if (clear) begin
      chan_cnt <= '0;
    end else if (emit_now && row_end) begin
      chan_cnt <= chan_cnt + cdp_bufin_pkg::chan_t'(1);
    end
  end

  // sideband beside win_data, same advance
  always_ff @(posedge nvdla_core_clk) begin
    if (emit_now) begin
      info_pos_w  <= sel_pos_w;
      info_width  <= cur_width;
      info_pos_c  <= chan_cnt;
      info_b_sync <= row_end;
      // last zero of flush closes the last channel row
      info_last_c <= flush_done;
    end
  end

endmodule

`default_nettype wire

//--- design/cdp_bufin.sv
// cdp buffer-in top
// input stage, control, window store, sideband and output stage
`default_nettype none

module cdp_bufin #(
  parameter int elem_w    = 8,
  parameter int max_width = 8
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      nvdla_core_rstn,
  input  logic                                      in_valid,
  output logic                                      in_ready,
  input  logic [elem_w-1:0]                         in_data,
  input  cdp_bufin_pkg::pos_w_t                     in_pos_w,
  input  cdp_bufin_pkg::pos_w_t                     in_width,
  input  logic                                      in_b_sync,
  input  logic                                      in_last_c,
  output logic                                      out_valid,
  input  logic                                      out_ready,
  output logic [cdp_bufin_pkg::win_taps*elem_w-1:0] out_data,
  output cdp_bufin_pkg::pos_w_t                     out_pos_w,
  output cdp_bufin_pkg::pos_w_t                     out_width,
  output cdp_bufin_pkg::chan_t                      out_pos_c,
  output logic                                      out_b_sync,
  output logic                                      out_last_c
);

  localparam int data_w = cdp_bufin_pkg::win_taps * elem_w;
  localparam int pos_w  = $bits(cdp_bufin_pkg::pos_w_t);
  localparam int in_w   = elem_w + 2 * pos_w + 2;
  localparam int out_w  = data_w + 2 * pos_w + $bits(cdp_bufin_pkg::chan_t) + 2;

  // held input beat
  logic                        beat_valid;
  logic                        beat_ready;
  logic [in_w-1:0]             beat_pd;
  logic [elem_w-1:0]           beat_data;
  cdp_bufin_pkg::pos_w_t       beat_pos_w;
  cdp_bufin_pkg::pos_w_t       beat_width;
  logic                        beat_b_sync;
  logic                        beat_last_c;

  // control
  cdp_bufin_pkg::bufin_state_e state;
  logic                        advance;
  logic                        push_zero;
  logic                        emit;
  logic                        clear;
  logic                        stage_en;
  logic                        flush_done;
  cdp_bufin_pkg::pos_w_t       flush_pos_w;
  cdp_bufin_pkg::pos_w_t       sel_pos_w;

  // window stage
  logic                        win_valid;
  logic [data_w-1:0]           win_data;
  cdp_bufin_pkg::pos_w_t       info_pos_w;
  cdp_bufin_pkg::pos_w_t       info_width;
  cdp_bufin_pkg::chan_t        info_pos_c;
  logic                        info_b_sync;
  logic                        info_last_c;
  logic [out_w-1:0]            out_pd;

  //////////////////////////////
  // input stage
  //////////////////////////////
  cdp_bufin_pipe #(.dw(in_w)) u_pipe_in (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_pd           ({in_last_c, in_b_sync, in_width, in_pos_w, in_data}),
    .out_valid       (beat_valid),
    .out_ready       (beat_ready),
    .out_pd          (beat_pd)
  );

  assign {beat_last_c, beat_b_sync, beat_width, beat_pos_w, beat_data} = beat_pd;

  //////////////////////////////
  // control
  //////////////////////////////
  cdp_bufin_fsm u_fsm (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .beat_valid      (beat_valid),
    .b_sync          (beat_b_sync),
    .last_c          (beat_last_c),
    .stage_en        (stage_en),
    .flush_done      (flush_done),
    .beat_ready      (beat_ready),
    .advance         (advance),
    .push_zero       (push_zero),
    .emit            (emit),
    .clear           (clear),
    .state           (state)
  );

  cdp_bufin_flush_cnt #(.max_width(max_width)) u_flush_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .state           (state),
    .advance         (advance),
    .in_width        (beat_width),
    .flush_pos_w     (flush_pos_w),
    .flush_done      (flush_done)
  );

  // flush walks its own positions
  assign sel_pos_w = (state == cdp_bufin_pkg::st_flush) ? flush_pos_w : beat_pos_w;

  //////////////////////////////
  // window and sideband
  //////////////////////////////
  cdp_bufin_window #(.elem_w(elem_w), .max_width(max_width)) u_window (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .advance         (advance),
    .push_zero       (push_zero),
    .clear           (clear),
    .sel_pos_w       (sel_pos_w),
    .din             (beat_data),
    .emit            (emit),
    .win_valid       (win_valid),
    .win_ready       (stage_en),
    .win_data        (win_data)
  );

  cdp_bufin_info u_info (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .advance         (advance),
    .emit            (emit),
    .clear           (clear),
    .state           (state),
    .sel_pos_w       (sel_pos_w),
    .in_width        (beat_width),
    .flush_done      (flush_done),
    .info_pos_w      (info_pos_w),
    .info_width      (info_width),
    .info_pos_c      (info_pos_c),
    .info_b_sync     (info_b_sync),
    .info_last_c     (info_last_c)
  );

  //////////////////////////////
  // output stage
  //////////////////////////////
  // its ready is the window stage enable
  cdp_bufin_pipe #(.dw(out_w)) u_pipe_out (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (win_valid),
    .in_ready        (stage_en),
    .in_pd           ({info_last_c, info_b_sync, info_pos_c, info_width, info_pos_w, win_data}),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_pd          (out_pd)
  );

  assign {out_last_c, out_b_sync, out_pos_c, out_width, out_pos_w, out_data} = out_pd;

endmodule

`default_nettype wire

//--- dv/tb_cdp_bufin.sv
// cdp buffer-in testbench
// directed cubes through the channel-window buffer, checked against a
// per-channel element model of the nine-lane windows
`default_nettype none

module tb_cdp_bufin;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int elem_w    = 8;
  localparam int max_width = 8;
  localparam int max_chans = 8;
  localparam int win_taps  = 9;
  localparam int half_win  = 4;
  localparam int data_w    = win_taps * elem_w;
  // input beats plus flush beats of every test
  localparam int total_beats = 2 * (3 * 6 + half_win * 3) + (2 * 5 + half_win * 2)
                             + (5 * 7 + half_win * 5) + (max_width * 4 + half_win * max_width);
  // four times for back-pressure, margin for reset, gaps and settling
  localparam int timeout_cycles = total_beats * 4 + 400;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [3:0]        pos_w;
    logic [3:0]        width;
    logic [7:0]        pos_c;
    logic              b_sync;
    logic              last_c;
  } window_beat_t;

  logic              nvdla_core_clk;
  logic              nvdla_core_rstn;
  logic              in_valid;
  logic              in_ready;
  logic [elem_w-1:0] in_data;
  logic [3:0]        in_pos_w;
  logic [3:0]        in_width;
  logic              in_b_sync;
  logic              in_last_c;
  logic              out_valid;
  logic              out_ready;
  logic [data_w-1:0] out_data;
  logic [3:0]        out_pos_w;
  logic [3:0]        out_width;
  logic [7:0]        out_pos_c;
  logic              out_b_sync;
  logic              out_last_c;

  int                seed = 69341;
  int                err_cnt = 0;
  int                recv_cnt = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                cycle_cnt = 0;
  bit                bp_en = 1'b0;
  bit                bp_pat [1024];
  // model: elements of the current cube, by channel then position
  logic [elem_w-1:0] cube_elem [max_chans][max_width];
  window_beat_t      exp_q [$];

  cdp_bufin #(.elem_w(elem_w), .max_width(max_width)) DUT (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_data         (in_data),
    .in_pos_w        (in_pos_w),
    .in_width        (in_width),
    .in_b_sync       (in_b_sync),
    .in_last_c       (in_last_c),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .out_pos_w       (out_pos_w),
    .out_width       (out_width),
    .out_pos_c       (out_pos_c),
    .out_b_sync      (out_b_sync),
    .out_last_c      (out_last_c)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #4 nvdla_core_clk = ~nvdla_core_clk;
  end

  // out_ready, high unless the toggle pattern runs
  initial begin
    int bp_idx;
    bp_idx = 0;
    out_ready = 1'b1;
    forever begin
      @(posedge nvdla_core_clk);
      out_ready <= bp_en ? bp_pat[bp_idx % 1024] : 1'b1;
      if (bp_en) begin
        bp_idx++;
      end
    end
  end

  // watchdog
  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge nvdla_core_clk);
      cycle_cnt++;
    end
    $display("timeout: no progress after %0d cycles, windows still pending: %0d",
             cycle_cnt, exp_q.size());
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////
  // model and checks
  //////////////////////////////
  task automatic check_field(input string name, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
    assert (got == exp) else begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // elements never zero, so a stale tap shows up as a mismatch
  task automatic make_cube(input int width, input int chans);
    for (int c = 0; c < chans; c++) begin
      for (int w = 0; w < width; w++) begin
        cube_elem[c][w] = elem_w'($random(seed)) | elem_w'(1);
      end
    end
  endtask

  // lane k of output channel o holds channel o-4+k, zero outside the cube
  task automatic queue_windows(input int width, input int chans);
    window_beat_t b;
    int           ch;
    for (int o = 0; o < chans; o++) begin
      for (int w = 0; w < width; w++) begin
        b.data = '0;
        for (int k = 0; k < win_taps; k++) begin
          ch = o - half_win + k;
          if (ch >= 0 && ch < chans) begin
            b.data[k*elem_w +: elem_w] = cube_elem[ch][w];
          end
        end
        b.pos_w  = 4'(w);
        b.width  = 4'(width);
        b.pos_c  = 8'(o);
        b.b_sync = (w == width - 1);
        b.last_c = (o == chans - 1) && (w == width - 1);
        exp_q.push_back(b);
      end
    end
  endtask

  // one accepted output beat against the head of the model
  task automatic check_beat();
    window_beat_t e;
    recv_cnt++;
    assert (exp_q.size() != 0) else begin
      $display("output beat at %0d ns arrived with no window left to expect", $time);
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_field("out_data", out_data, e.data);
      check_field("out_pos_w", data_w'(out_pos_w), data_w'(e.pos_w));
      check_field("out_width", data_w'(out_width), data_w'(e.width));
      check_field("out_pos_c", data_w'(out_pos_c), data_w'(e.pos_c));
      check_field("out_b_sync", data_w'(out_b_sync), data_w'(e.b_sync));
      check_field("out_last_c", data_w'(out_last_c), data_w'(e.last_c));
    end
  endtask

  // handshake seen at the falling edge, taken at the next rising edge
  initial begin
    forever begin
      @(negedge nvdla_core_clk);
      if (out_valid && out_ready) begin
        check_beat();
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic wait_accept();
    bit acc;
    acc = 1'b0;
    while (!acc) begin
      @(negedge nvdla_core_clk);
      acc = in_ready;
      @(posedge nvdla_core_clk);
    end
  endtask

  task automatic send_cube(input int width, input int chans, input bit gaps);
    int gap;
    for (int c = 0; c < chans; c++) begin
      for (int w = 0; w < width; w++) begin
        if (gaps) begin
          gap = $random(seed) & 3;
          if (gap != 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge nvdla_core_clk);
          end
        end
        in_valid  <= 1'b1;
        in_data   <= cube_elem[c][w];
        in_pos_w  <= 4'(w);
        in_width  <= 4'(width);
        in_b_sync <= (w == width - 1);
        in_last_c <= (c == chans - 1) && (w == width - 1);
        wait_accept();
      end
    end
    in_valid <= 1'b0;
  endtask

  // all windows out, then idle with the flush finished
  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge nvdla_core_clk);
    end
    bp_en <= 1'b0;
    repeat (8) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    check_field("out_valid", data_w'(out_valid), data_w'(1'b0));
    check_field("in_ready", data_w'(in_ready), data_w'(1'b1));
    @(posedge nvdla_core_clk);
  endtask

  task automatic close_test(input string name, input int errs_before, input int beats_before,
                            input int beats_exp);
    int beats;
    beats = recv_cnt - beats_before;
    assert (beats == beats_exp) else begin
      $display("%s received %0d output beats where %0d were due", name, beats, beats_exp);
      err_cnt++;
    end
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: %0d beats, ok", name, beats);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors, failed", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_state_check();
    int errs;
    errs = err_cnt;
    @(negedge nvdla_core_clk);
    check_field("out_valid", data_w'(out_valid), data_w'(1'b0));
    check_field("in_ready", data_w'(in_ready), data_w'(1'b1));
    @(posedge nvdla_core_clk);
    close_test("reset_state", errs, recv_cnt, 0);
  endtask

  task automatic single_cube();
    int errs;
    int beats;
    errs  = err_cnt;
    beats = recv_cnt;
    make_cube(3, 6);
    queue_windows(3, 6);
    send_cube(3, 6, 1'b0);
    wait_drained();
    close_test("single_cube", errs, beats, 18);
  endtask

  // same elements as single_cube, with stalls on both sides
  task automatic toggled_ready_cube();
    int errs;
    int beats;
    errs  = err_cnt;
    beats = recv_cnt;
    for (int i = 0; i < 1024; i++) begin
      bp_pat[i] = ($random(seed) & 1) != 0;
    end
    bp_en <= 1'b1;
    queue_windows(3, 6);
    send_cube(3, 6, 1'b1);
    wait_drained();
    close_test("toggled_ready", errs, beats, 18);
  endtask

  // second cube follows at once, exact lanes catch any leftover
  task automatic back_to_back_cubes();
    int errs;
    int beats;
    errs  = err_cnt;
    beats = recv_cnt;
    make_cube(2, 5);
    queue_windows(2, 5);
    send_cube(2, 5, 1'b0);
    make_cube(5, 7);
    queue_windows(5, 7);
    send_cube(5, 7, 1'b0);
    wait_drained();
    close_test("back_to_back", errs, beats, 45);
  endtask

  task automatic minimum_channel_cube();
    int errs;
    int beats;
    errs  = err_cnt;
    beats = recv_cnt;
    make_cube(max_width, 4);
    queue_windows(max_width, 4);
    send_cube(max_width, 4, 1'b0);
    wait_drained();
    close_test("min_channels", errs, beats, max_width * 4);
  endtask

  initial begin
    nvdla_core_rstn = 1'b0;
    in_valid        = 1'b0;
    in_data         = '0;
    in_pos_w        = '0;
    in_width        = '0;
    in_b_sync       = 1'b0;
    in_last_c       = 1'b0;
    repeat (8) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(posedge nvdla_core_clk);
    reset_state_check();
    single_cube();
    toggled_ready_cube();
    back_to_back_cubes();
    minimum_channel_cube();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/cdp_bufin_pkg.sv
design/cdp_bufin_pipe.sv
design/cdp_bufin_fsm.sv
design/cdp_bufin_flush_cnt.sv
design/cdp_bufin_window.sv
design/cdp_bufin_info.sv
design/cdp_bufin.sv
dv/tb_cdp_bufin.sv

//--- run.sh
#!/bin/sh
# compile and run the cdp_bufin testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module tb_cdp_bufin
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cdp_bufin)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
